// File: compile.f
logic/lsu_pkg.sv
logic/mem_port_if.sv
logic/store_lane_align.sv
logic/load_extract.sv
logic/data_ram.sv
logic/lsu_ctrl.sv
logic/lsu_top.sv
sim/tb_lsu.sv

// File: sim/tb_lsu.sv
`timescale 1ns/100ps

module tb_lsu
  import lsu_pkg::*;
();

  localparam logic [xlen-1:0] ram_base = 64'h8000_0000;
  localparam int ram_words = 256;
  localparam logic [xlen-1:0] ram_top = ram_base + 64'(8 * ram_words);
  // words that the tests touch, all written first
  localparam int test_words = 16;
  localparam int reset_cycles = 8;
  // first write, lanes, extend, misaligned, range, back to back
  localparam int total_reqs = 17 + 28 + 48 + 36 + 18 + 32;
  localparam int timeout_cycles = 2 * total_reqs + reset_cycles;

  logic clk, rst, req, req_store, req_unsigned;
  access_size_t req_size;
  logic [xlen-1:0] req_addr, req_wdata, load_data;
  logic load_valid, fault;
  fault_cause_t fault_cause;

  // expected response of the request being driven, then one stage later
  logic exp_valid, exp_fault, chk_valid, chk_fault;
  logic [xlen-1:0] exp_data, chk_data;
  fault_cause_t exp_cause, chk_cause;
  logic rst_q = 1'b0;

  logic [7:0] shadow [8*ram_words];
  logic [31:0] lcg_state = 32'd38289;
  int cycles = 0;
  int errors = 0;
  int err_mark = 0;
  int tests_run = 0;
  int tests_failed = 0;
  string test_name = "reset_and_first_load";

  lsu_top #(.ram_base(ram_base), .ram_words(ram_words)) i_lsu_top (.*);

  always #20 clk = ~clk;

  always @(posedge clk) begin
    chk_valid <= exp_valid;
    chk_fault <= exp_fault;
    chk_cause <= exp_cause;
    chk_data  <= exp_data;
    rst_q     <= rst;
    cycles    <= cycles + 1;
    if (cycles > timeout_cycles) begin
      $display("run did not finish within %0d cycles", timeout_cycles);
      $display("Something failed");
      $finish;
    end
  end

  // valid, fault and cause checked as one status word
  status_check: assert property (@(posedge clk) disable iff (rst)
      {load_valid, fault, fault_cause} === {chk_valid, chk_fault, chk_cause})
    else begin
      errors++;
      $display("** Error %s status expected %b actual %b", test_name,
               $sampled({chk_valid, chk_fault, chk_cause}),
               $sampled({load_valid, fault, fault_cause}));
    end

  data_check: assert property (@(posedge clk) disable iff (rst)
      chk_valid |-> load_data === chk_data)
    else begin
      errors++;
      $display("** Error %s load_data expected %h actual %h", test_name,
               $sampled(chk_data), $sampled(load_data));
    end

  reset_check: assert property (@(posedge clk)
      rst_q |-> !load_valid && !fault && fault_cause == cause_none)
    else begin
      errors++;
      $display("load result or fault seen during reset");
    end

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    // upper bits of an LCG are the better ones
    return {lcg_state[15:0], lcg_state[31:16]};
  endfunction

  function automatic logic [xlen-1:0] rand_addr(access_size_t size);
    logic [2:0] off;
    off = 3'(next_rand() % 8);
    off = off & ~3'((1 << size) - 1);
    return ram_base + 64'(8 * (next_rand() % test_words)) + 64'(off);
  endfunction

  // drive one request and work out its response from the shadow bytes
  task automatic issue(logic store, access_size_t size, logic uns, logic [xlen-1:0] addr,
                       logic [xlen-1:0] data);
    int nbytes;
    logic [xlen-1:0] rel;
    logic [xlen-1:0] raw;
    nbytes = 1 << size;
    rel = addr - ram_base;
    raw = '0;
    req = 1'b1;
    req_store = store;
    req_size = size;
    req_unsigned = uns;
    req_addr = addr;
    req_wdata = data;
    exp_valid = 1'b0;
    exp_fault = 1'b0;
    exp_cause = cause_none;
    if (!rst && (addr[2:0] % nbytes != 0)) begin
      exp_fault = 1'b1;
      exp_cause = cause_misaligned;
    end else if (!rst && (addr < ram_base || addr >= ram_top)) begin
      exp_fault = 1'b1;
      exp_cause = cause_range;
    end else if (!rst && store) begin
      for (int i = 0; i < nbytes; i++) begin
        shadow[rel + i] = data[8*i +: 8];
      end
    end else if (!rst) begin
      for (int i = 0; i < nbytes; i++) begin
        raw[8*i +: 8] = shadow[rel + i];
      end
      for (int i = 8 * nbytes; i < xlen; i++) begin
        raw[i] = !uns && raw[8*nbytes-1];
      end
      exp_valid = 1'b1;
      exp_data = raw;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic idle_cycle();
    req = 1'b0;
    exp_valid = 1'b0;
    exp_fault = 1'b0;
    exp_cause = cause_none;
    @(posedge clk);
    #2;
  endtask

  task automatic load_dword(int word);
    issue(1'b0, size_dword, 1'b0, ram_base + 64'(8 * word), '0);
  endtask

  task automatic start_test(string name);
    test_name = name;
    err_mark = errors;
  endtask

  task automatic finish_test();
    // two idle cycles let the last response get checked
    idle_cycle();
    idle_cycle();
    tests_run++;
    if (errors == err_mark) begin
      $display("test %s passed", test_name);
    end else begin
      tests_failed++;
      $display("test %s failed with %0d errors", test_name, errors - err_mark);
    end
  endtask

  initial begin
    logic [xlen-1:0] addr;
    logic [xlen-1:0] data;
    logic [2:0] off;
    access_size_t sz;
    clk = 1'b0;
    rst = 1'b1;
    req = 1'b0;
    req_store = 1'b0;
    req_size = size_byte;
    req_unsigned = 1'b0;
    req_addr = '0;
    req_wdata = '0;
    exp_valid = 1'b0;
    exp_fault = 1'b0;
    exp_cause = cause_none;
    exp_data = '0;

    start_test("reset_and_first_load");
    // loads during reset are ignored
    repeat (reset_cycles) begin
      issue(1'b0, size_dword, 1'b0, ram_base, '0);
    end
    rst = 1'b0;
    for (int w = 0; w < test_words; w++) begin
      issue(1'b1, size_dword, 1'b0, ram_base + 64'(8 * w), {next_rand(), next_rand()});
    end
    load_dword(0);
    finish_test();

    start_test("lane_stores");
    for (int s = 0; s < 3; s++) begin
      for (int o = 0; o < 8; o += (1 << s)) begin
        issue(1'b1, access_size_t'(s), 1'b0, ram_base + 64'(24 + o), {next_rand(), next_rand()});
        load_dword(3);
      end
    end
    finish_test();

    start_test("load_extend");
    for (int k = 0; k < 24; k++) begin
      sz = access_size_t'(k % 3);
      addr = rand_addr(sz);
      data = {next_rand(), next_rand()};
      // top bit of the access clear for six rounds, then set
      data[8*(1 << sz) - 1] = 1'((k / 6) % 2);
      issue(1'b1, sz, 1'b0, addr, data);
      issue(1'b0, sz, 1'((k / 3) % 2), addr, '0);
    end
    finish_test();

    start_test("misaligned");
    for (int k = 0; k < 12; k++) begin
      sz = access_size_t'(k % 3 + 1);
      off = 3'(next_rand() % 8);
      if (off % (1 << sz) == 0) begin
        off = off + 3'd1;
      end
      addr = ram_base + 64'(8 * (next_rand() % test_words)) + 64'(off);
      issue(1'b1, sz, 1'b0, addr, {next_rand(), next_rand()});
      issue(1'b0, sz, 1'b0, addr, '0);
      load_dword(int'((addr - ram_base) / 8));
    end
    finish_test();

    start_test("out_of_range");
    for (int k = 0; k < 6; k++) begin
      case (k)
        0: addr = ram_base - 1;
        1: addr = ram_base - 8;
        2: addr = '0;
        3: addr = ram_top;
        4: addr = ram_top + 8;
        default: addr = '1;
      endcase
      issue(1'b1, size_byte, 1'b0, addr, {next_rand(), next_rand()});
      issue(1'b0, size_byte, 1'b1, addr, '0);
      // an address past the top would alias word 0
      load_dword(0);
    end
    finish_test();

    start_test("back_to_back");
    for (int k = 0; k < 32; k++) begin
      sz = access_size_t'(next_rand() % 4);
      issue(1'b0, sz, 1'(next_rand() % 2), rand_addr(sz), '0);
    end
    finish_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: logic/lsu_top.sv
`timescale 1ns/100ps

module lsu_top
  import lsu_pkg::*;
#(
  parameter logic [xlen-1:0] ram_base  = 64'h8000_0000,
  parameter int              ram_words = 256
)
(
  input  logic            clk,
  input  logic            rst,
  input  logic            req,
  input  logic            req_store,
  input  access_size_t    req_size,
  input  logic            req_unsigned,
  input  logic [xlen-1:0] req_addr,
  input  logic [xlen-1:0] req_wdata,
  output logic            load_valid,
  output logic [xlen-1:0] load_data,
  output logic            fault,
  output fault_cause_t    fault_cause
);

  access_size_t          size;
  logic [2:0]            offset;
  logic [xlen-1:0]       wdata;
  logic [lane_count-1:0] lane_mask;
  logic [xlen-1:0]       wdata_lanes;
  logic                  misaligned;
  logic [xlen-1:0]       extracted;

  mem_port_if #(.ram_words(ram_words)) mem_port ();

  lsu_ctrl #(
    .ram_base  (ram_base),
    .ram_words (ram_words)
  ) i_lsu_ctrl (
    .clk          (clk),
    .rst          (rst),
    .req          (req),
    .req_store    (req_store),
    .req_size     (req_size),
    .req_unsigned (req_unsigned),
    .req_addr     (req_addr),
    .req_wdata    (req_wdata),
    .lane_mask    (lane_mask),
    .wdata_lanes  (wdata_lanes),
    .misaligned   (misaligned),
    .extracted    (extracted),
    .size_out     (size),
    .offset_out   (offset),
    .wdata_out    (wdata),
    .port         (mem_port.ctrl),
    .load_valid   (load_valid),
    .load_data    (load_data),
    .fault        (fault),
    .fault_cause  (fault_cause)
  );

  store_lane_align i_store_lane_align (
    .size        (size),
    .offset      (offset),
    .wdata_in    (wdata),
    .lane_mask   (lane_mask),
    .wdata_lanes (wdata_lanes),
    .misaligned  (misaligned)
  );

  load_extract i_load_extract (
    .rdata_word  (mem_port.rdata),
    .lane_mask   (lane_mask),
    .offset      (offset),
    .size        (size),
    .is_unsigned (req_unsigned),
    .value       (extracted)
  );

  data_ram #(.ram_words(ram_words)) i_data_ram (
    .clk  (clk),
    .port (mem_port.ram)
  );

endmodule

// File: logic/lsu_ctrl.sv
`timescale 1ns/100ps

module lsu_ctrl
  import lsu_pkg::*;
#(
  parameter logic [xlen-1:0] ram_base  = 64'h8000_0000,
  parameter int              ram_words = 256
)
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  req,
  input  logic                  req_store,
  input  access_size_t          req_size,
  input  logic                  req_unsigned,
  input  logic [xlen-1:0]       req_addr,
  input  logic [xlen-1:0]       req_wdata,
  input  logic [lane_count-1:0] lane_mask,
  input  logic [xlen-1:0]       wdata_lanes,
  input  logic                  misaligned,
  input  logic [xlen-1:0]       extracted,
  output access_size_t          size_out,
  output logic [2:0]            offset_out,
  output logic [xlen-1:0]       wdata_out,
  mem_port_if.ctrl              port,
  output logic                  load_valid,
  output logic [xlen-1:0]       load_data,
  output logic                  fault,
  output fault_cause_t          fault_cause
);

  localparam int              index_w   = $clog2(ram_words);
  localparam logic [xlen-1:0] ram_bytes = xlen'(ram_words) << 3;

  logic [xlen-1:0] rel_addr;
  logic            in_range;
  fault_cause_t    cause;
  logic            good_req;
  logic            store_hit;
  logic            load_hit;

  assign size_out   = req_size;
  assign offset_out = req_addr[2:0];
  assign wdata_out  = req_wdata;

  // addresses below the base wrap to a large value and fail the same check
  assign rel_addr = req_addr - ram_base;
  assign in_range = (rel_addr < ram_bytes);

  // misalignment wins when both apply
  always_comb begin
    if (misaligned) begin
      cause = cause_misaligned;
    end else if (!in_range) begin
      cause = cause_range;
    end else begin
      cause = cause_none;
    end
  end

  assign good_req  = req && !rst && (cause == cause_none);
  assign store_hit = good_req && req_store;
  assign load_hit  = good_req && !req_store;

  assign port.ena        = good_req;
  assign port.wen        = store_hit;
  assign port.word_index = rel_addr[index_w+2:3];
  assign port.wmask      = lane_mask & {lane_count{store_hit}};
  assign port.wdata      = wdata_lanes;

  // one stage for load results and faults
  always_ff @(posedge clk) begin
    if (rst) begin
      load_valid  <= 1'b0;
      fault       <= 1'b0;
      fault_cause <= cause_none;
    end else begin
      load_valid  <= load_hit;
      fault       <= req && (cause != cause_none);
      fault_cause <= req ? cause : cause_none;
    end
  end

  always_ff @(posedge clk) begin
    if (load_hit) begin
      load_data <= extracted;
    end
  end

  valid_xor_fault: assert property (@(posedge clk) !(load_valid && fault))
    else $error("load result and fault in the same cycle");

  no_access_in_reset: assert property (@(posedge clk) rst |-> !port.ena)
    else $error("memory access while in reset");

endmodule

// File: logic/data_ram.sv
`timescale 1ns/100ps

module data_ram
  import lsu_pkg::*;
#(
  parameter int ram_words = 256
)
(
  input  logic       clk,
  mem_port_if.ram    port
);

  localparam int index_w = $clog2(ram_words);

  logic [xlen-1:0]    mem [ram_words];
  logic [index_w-1:0] word_sel;

  assign word_sel = port.word_index;

  // per-byte write, only the enabled lanes change
  always_ff @(posedge clk) begin
    if (port.ena && port.wen) begin
      for (int i = 0; i < lane_count; i++) begin
        if (port.wmask[i]) begin
          mem[word_sel][8*i +: 8] <= port.wdata[8*i +: 8];
        end
      end
    end
  end

  // read is combinational; a store in the previous cycle is visible here
  assign port.rdata = mem[word_sel];

  // the write enable only qualifies an active access
  wen_needs_ena: assert property (@(posedge clk) port.wen |-> port.ena)
    else $error("write enable without access strobe");

endmodule

// File: logic/load_extract.sv
`timescale 1ns/100ps

module load_extract
  import lsu_pkg::*;
(
  input  logic [xlen-1:0]       rdata_word,
  input  logic [lane_count-1:0] lane_mask,
  input  logic [2:0]            offset,
  input  access_size_t          size,
  input  logic                  is_unsigned,
  output logic [xlen-1:0]       value
);

  logic [xlen-1:0] byte_keep;
  logic [xlen-1:0] shifted;
  logic            sign;

  // one lane bit widened to a full byte
  always_comb begin
    for (int i = 0; i < lane_count; i++) begin
      byte_keep[8*i +: 8] = {8{lane_mask[i]}};
    end
  end

  // addressed bytes down to bit 0
  assign shifted = (rdata_word & byte_keep) >> {offset, 3'b000};

  // top bit of the accessed size, or zero for unsigned loads
  always_comb begin
    case (size)
      size_byte: sign = shifted[7];
      size_half: sign = shifted[15];
      size_word: sign = shifted[31];
      default:   sign = shifted[xlen-1];
    endcase
    if (is_unsigned) begin
      sign = 1'b0;
    end
  end

  always_comb begin
    case (size)
      size_byte: begin
        value = {{(xlen-8){sign}}, shifted[7:0]};
      end
      size_half: begin
        value = {{(xlen-16){sign}}, shifted[15:0]};
      end
      size_word: begin
        value = {{(xlen-32){sign}}, shifted[31:0]};
      end
      default: begin
        // full word, nothing to extend
        value = shifted;
      end
    endcase
  end

endmodule

// File: logic/store_lane_align.sv
`timescale 1ns/100ps

module store_lane_align
  import lsu_pkg::*;
(
  input  access_size_t          size,
  input  logic [2:0]            offset,
  input  logic [xlen-1:0]       wdata_in,
  output logic [lane_count-1:0] lane_mask,
  output logic [xlen-1:0]       wdata_lanes,
  output logic                  misaligned
);

  logic [lane_count-1:0] base_mask;
  logic                  aligned;

  // lanes for an access at offset zero, and the alignment rule per size
  always_comb begin
    case (size)
      size_byte: begin
        base_mask = lane_count'(1);
        aligned   = 1'b1;
      end
      size_half: begin
        base_mask = lane_count'(3);
        aligned   = (offset[0] == 1'b0);
      end
      size_word: begin
        base_mask = lane_count'(15);
        aligned   = (offset[1:0] == 2'b00);
      end
      default: begin
        base_mask = '1;
        aligned   = (offset == 3'b000);
      end
    endcase
  end

  assign misaligned = !aligned;

  // no lanes at all for a misaligned access
  assign lane_mask = aligned ? (base_mask << offset) : '0;

  // byte 0 of the store data moves to the addressed lane
  assign wdata_lanes = wdata_in << {offset, 3'b000};

  // an aligned access enables exactly 1, 2, 4 or 8 lanes
  always_comb begin
    if (!misaligned) begin
      assert final ($countones(lane_mask) == (1 << size))
        else $error("lane mask %b does not fit size %s", lane_mask, size.name());
    end
  end

endmodule

// File: logic/mem_port_if.sv
`timescale 1ns/100ps

interface mem_port_if
  import lsu_pkg::*;
#(
  parameter int ram_words = 256
);

  localparam int index_w = $clog2(ram_words);

  // access strobe, high for exactly the cycle of the access
  logic                  ena;
  logic                  wen;
  logic [index_w-1:0]    word_index;
  // byte-lane write enables
  logic [lane_count-1:0] wmask;
  logic [xlen-1:0]       wdata;
  // combinational read of word_index
  logic [xlen-1:0]       rdata;

  modport ctrl (
    output ena, wen, word_index, wmask, wdata
  );

  modport ram (
    input  ena, wen, word_index, wmask, wdata,
    output rdata
  );

endinterface

// File: logic/lsu_pkg.sv
package lsu_pkg;

  // data and address width of the core
  localparam int xlen = 64;

  // byte lanes in one data word, also the write mask width
  localparam int lane_count = xlen / 8;

  // access size as encoded by the load/store instructions
  typedef enum logic [1:0] {
    size_byte  = 2'b00,
    size_half  = 2'b01,
    size_word  = 2'b10,
    size_dword = 2'b11
  } access_size_t;

  // reason for a rejected request
  typedef enum logic [1:0] {
    cause_none       = 2'b00,
    cause_misaligned = 2'b01,
    cause_range      = 2'b10
  } fault_cause_t;

endpackage
